// File: hw/emesh_pkg.sv
//==========================================================================
// eMesh transaction field widths and datamode encoding, shared by the
// translator and the top level. Pull in with a wildcard import.
//==========================================================================
`default_nettype none

package emesh_pkg;

   // transaction field widths
   localparam int EMESH_AW    = 32;   // dst/src address
   localparam int EMESH_DW    = 32;   // data payload
   localparam int EMESH_CTRLW = 4;    // ctrlmode field

   // translated destination address, full physical space
   localparam int EMESH_PAW   = 64;

   // access size of a transaction, carried through untouched
   typedef enum logic [1:0]
   {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } emesh_datamode_t;

endpackage

`default_nettype wire

// File: hw/emmu_pkg.sv
//==========================================================================
// Config port widths, translation table entry layout and config op codes
// for the eMesh MMU. Import where the table or the config port is used.
//==========================================================================
`default_nettype none

package emmu_pkg;

   // config (mi) port
   localparam int MI_AW = 16;   // byte address
   localparam int MI_DW = 32;

   // mi_addr layout
   localparam int MI_HALF_BIT = 2;   // 0 = entry[31:0], 1 = entry[47:32]
   localparam int MI_IDX_LSB  = 3;   // table index starts here

   // stored entry, wide enough for PAW-AW+IDW with IDW up to 16
   localparam int TBL_W      = 48;
   localparam int TBL_NLANES = TBL_W / 8;   // byte write lanes

   // lane enables for each half of an entry
   localparam logic [TBL_NLANES-1:0] TBL_LO_LANES = 6'b001111;
   localparam logic [TBL_NLANES-1:0] TBL_HI_LANES = 6'b110000;

   // what the config port does this cycle
   typedef enum logic [1:0]
   {
      MI_IDLE  = 2'd0,
      MI_WRITE = 2'd1,
      MI_READ  = 2'd2
   } emmu_mi_op_t;

endpackage

`default_nettype wire

// File: hw/emmu_table.sv
//==========================================================================
// Dual-port translation table. Port A serves the config side with byte
// lane writes and read-first data, port B is the registered lookup read
// used by the translator pipeline.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module emmu_table
   import emmu_pkg::*;
#(
   parameter int IDW = 12   // index width, 2**IDW entries
)
(
   input  wire                    clk,

   // port A, config read/write
   input  wire                    tbl_cfg_en,
   input  wire [TBL_NLANES-1:0]   tbl_cfg_wr_en,
   input  wire [IDW-1:0]          tbl_cfg_idx,
   input  wire [TBL_W-1:0]        tbl_cfg_wdata,
   output logic [TBL_W-1:0]       tbl_cfg_rdata,

   // port B, lookup read
   input  wire                    tbl_lk_en,
   input  wire [IDW-1:0]          tbl_lk_idx,
   output logic [TBL_W-1:0]       tbl_lk_data
);

   localparam int DEPTH = 1 << IDW;

   logic [TBL_W-1:0] mem [0:DEPTH-1];   // contents undefined until written

   // port A: old data out, then lane writes
   always_ff @(posedge clk)
   begin
      if (tbl_cfg_en)
      begin
         tbl_cfg_rdata <= mem[tbl_cfg_idx];   // read-first
         for (int i = 0; i < TBL_NLANES; i++)
         begin
            if (tbl_cfg_wr_en[i])
            begin
               mem[tbl_cfg_idx][i*8 +: 8] <= tbl_cfg_wdata[i*8 +: 8];
            end
         end
      end
   end

   // port B: holds last lookup when idle
   always_ff @(posedge clk)
   begin
      if (tbl_lk_en)
      begin
         tbl_lk_data <= mem[tbl_lk_idx];   // same-cycle write not seen here
      end
   end

   // an X index would corrupt or read a random entry
   a_cfg_idx_known : assert property (@(posedge clk)
      tbl_cfg_en |-> !$isunknown(tbl_cfg_idx))
      else $error("emmu_table: config index unknown while enabled");

   a_lk_idx_known : assert property (@(posedge clk)
      tbl_lk_en |-> !$isunknown(tbl_lk_idx))
      else $error("emmu_table: lookup index unknown while enabled");

endmodule

`default_nettype wire

// File: hw/emmu_cfg.sv
//==========================================================================
// Config port decoder for the MMU table. Turns mi_* strobes into half-entry
// writes and reads on table port A, and returns read data on mi_dout.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module emmu_cfg
   import emmu_pkg::*;
#(
   parameter int IDW = 12
)
(
   input  wire                    clk,
   input  wire                    reset,

   // config port
   input  wire                    mi_en,
   input  wire                    mi_we,
   input  wire [MI_AW-1:0]        mi_addr,
   input  wire [MI_DW-1:0]        mi_din,
   output logic [MI_DW-1:0]       mi_dout,

   // table port A
   output logic                   tbl_cfg_en,
   output logic [TBL_NLANES-1:0]  tbl_cfg_wr_en,
   output logic [IDW-1:0]         tbl_cfg_idx,
   output logic [TBL_W-1:0]       tbl_cfg_wdata,
   input  wire [TBL_W-1:0]        tbl_cfg_rdata
);

   // address wide enough to slice any IDW, upper bits zero past MI_AW
   localparam int XW = (IDW + MI_IDX_LSB > MI_AW) ? IDW + MI_IDX_LSB : MI_AW;

   emmu_mi_op_t      mi_op;
   logic [XW-1:0]    mi_addr_x;
   logic             half_sel;
   logic             rd_q;          // read issued last cycle
   logic             half_q;        // its half select
   logic [MI_DW-1:0] rd_data;       // steered table data
   logic [MI_DW-1:0] dout_q;        // last read result

   always_comb
   begin
      if (!mi_en)
         mi_op = MI_IDLE;
      else if (mi_we)
         mi_op = MI_WRITE;
      else
         mi_op = MI_READ;
   end

   assign mi_addr_x = XW'(mi_addr);
   assign half_sel  = mi_addr[MI_HALF_BIT];

   assign tbl_cfg_en  = (mi_op != MI_IDLE);
   assign tbl_cfg_idx = mi_addr_x[IDW+MI_IDX_LSB-1:MI_IDX_LSB];

   // only the addressed half gets lanes
   assign tbl_cfg_wr_en = (mi_op != MI_WRITE) ? '0 :
                          half_sel            ? TBL_HI_LANES :
                                                TBL_LO_LANES;

   // same word lands in both halves, lanes pick one
   assign tbl_cfg_wdata = {mi_din[TBL_W-MI_DW-1:0], mi_din};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_q   <= 1'b0;
         half_q <= 1'b0;
         dout_q <= '0;
      end
      else
      begin
         rd_q <= (mi_op == MI_READ);
         if (mi_op == MI_READ)
            half_q <= half_sel;
         if (rd_q)
            dout_q <= rd_data;   // keep until next read
      end
   end

   // high half is 16 bits, zero-extended
   assign rd_data = half_q ? MI_DW'(tbl_cfg_rdata[TBL_W-1:MI_DW]) :
                             tbl_cfg_rdata[MI_DW-1:0];

   // fresh table data in the cycle after the strobe, held value after that
   assign mi_dout = rd_q ? rd_data : dout_q;

   // config accesses are word aligned
   a_mi_aligned : assert property (@(posedge clk) disable iff (reset)
      mi_en |-> (mi_addr[1:0] == 2'b00))
      else $error("emmu_cfg: unaligned mi_addr %h", mi_addr);

endmodule

`default_nettype wire

// File: hw/emmu.sv
//==========================================================================
// eMesh address translator pipeline. Starts the table lookup from the top
// IDW dstaddr bits, delays the rest of the transaction one cycle to line up
// with the lookup, then builds the 64-bit physical destination address.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module emmu
   import emesh_pkg::*;
   import emmu_pkg::*;
#(
   parameter int IDW = 12
)
(
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      mmu_en,   // level, applied at output

   // incoming transaction
   input  wire                      emesh_access_in,
   input  wire                      emesh_write_in,
   input  emesh_datamode_t          emesh_datamode_in,
   input  wire [EMESH_CTRLW-1:0]    emesh_ctrlmode_in,
   input  wire [EMESH_AW-1:0]       emesh_dstaddr_in,
   input  wire [EMESH_AW-1:0]       emesh_srcaddr_in,
   input  wire [EMESH_DW-1:0]       emesh_data_in,

   // translated transaction
   output logic                     emmu_access_out,
   output logic                     emmu_write_out,
   output emesh_datamode_t          emmu_datamode_out,
   output logic [EMESH_CTRLW-1:0]   emmu_ctrlmode_out,
   output logic [EMESH_PAW-1:0]     emmu_dstaddr_out,
   output logic [EMESH_AW-1:0]      emmu_srcaddr_out,
   output logic [EMESH_DW-1:0]      emmu_data_out,

   // table port B
   output logic                     tbl_lk_en,
   output logic [IDW-1:0]           tbl_lk_idx,
   input  wire [TBL_W-1:0]          tbl_lk_data
);

   localparam int EW = EMESH_PAW - EMESH_AW + IDW;   // entry bits used
   localparam int OW = EMESH_AW - IDW;               // untranslated offset

   logic [EMESH_AW-1:0] dstaddr_q;

   // lookup launched with the transaction
   assign tbl_lk_en  = emesh_access_in;
   assign tbl_lk_idx = emesh_dstaddr_in[EMESH_AW-1 -: IDW];

   always_ff @(posedge clk)
   begin
      if (reset)
         emmu_access_out <= 1'b0;
      else
         emmu_access_out <= emesh_access_in;
   end

   // payload, loaded per transaction
   always_ff @(posedge clk)
   begin
      if (emesh_access_in)
      begin
         emmu_write_out    <= emesh_write_in;
         emmu_datamode_out <= emesh_datamode_in;
         emmu_ctrlmode_out <= emesh_ctrlmode_in;
         emmu_srcaddr_out  <= emesh_srcaddr_in;
         emmu_data_out     <= emesh_data_in;
         dstaddr_q         <= emesh_dstaddr_in;   // matches table latency
      end
   end

   // page from the table, offset from the original address
   always_comb
   begin
      if (mmu_en)
         emmu_dstaddr_out = {tbl_lk_data[EW-1:0], dstaddr_q[OW-1:0]};
      else
         emmu_dstaddr_out = EMESH_PAW'(dstaddr_q);   // bypass, zero-ext
   end

   // downstream keys everything off this strobe
   a_access_known : assert property (@(posedge clk) disable iff (reset)
      !$isunknown(emmu_access_out))
      else $error("emmu: emmu_access_out unknown");

endmodule

`default_nettype wire

// File: hw/emmu_top.sv
//==========================================================================
// eMesh MMU top level. Ties the config decoder, the translation table and
// the translator together; IDW set here sizes the whole subsystem.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module emmu_top
   import emesh_pkg::*;
   import emmu_pkg::*;
#(
   parameter int IDW = 12   // 8..16
)
(
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      mmu_en,

   // config port
   input  wire                      mi_en,
   input  wire                      mi_we,
   input  wire [MI_AW-1:0]          mi_addr,
   input  wire [MI_DW-1:0]          mi_din,
   output logic [MI_DW-1:0]         mi_dout,

   // eMesh in
   input  wire                      emesh_access_in,
   input  wire                      emesh_write_in,
   input  emesh_datamode_t          emesh_datamode_in,
   input  wire [EMESH_CTRLW-1:0]    emesh_ctrlmode_in,
   input  wire [EMESH_AW-1:0]       emesh_dstaddr_in,
   input  wire [EMESH_AW-1:0]       emesh_srcaddr_in,
   input  wire [EMESH_DW-1:0]       emesh_data_in,

   // eMesh out, translated
   output logic                     emmu_access_out,
   output logic                     emmu_write_out,
   output emesh_datamode_t          emmu_datamode_out,
   output logic [EMESH_CTRLW-1:0]   emmu_ctrlmode_out,
   output logic [EMESH_PAW-1:0]     emmu_dstaddr_out,
   output logic [EMESH_AW-1:0]      emmu_srcaddr_out,
   output logic [EMESH_DW-1:0]      emmu_data_out
);

   // table port A
   logic                  tbl_cfg_en;
   logic [TBL_NLANES-1:0] tbl_cfg_wr_en;
   logic [IDW-1:0]        tbl_cfg_idx;
   logic [TBL_W-1:0]      tbl_cfg_wdata;
   logic [TBL_W-1:0]      tbl_cfg_rdata;

   // table port B
   logic                  tbl_lk_en;
   logic [IDW-1:0]        tbl_lk_idx;
   logic [TBL_W-1:0]      tbl_lk_data;

   emmu_cfg #(.IDW(IDW)) u_emmu_cfg
   (
      .clk           (clk),
      .reset         (reset),
      .mi_en         (mi_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .mi_din        (mi_din),
      .mi_dout       (mi_dout),
      .tbl_cfg_en    (tbl_cfg_en),
      .tbl_cfg_wr_en (tbl_cfg_wr_en),
      .tbl_cfg_idx   (tbl_cfg_idx),
      .tbl_cfg_wdata (tbl_cfg_wdata),
      .tbl_cfg_rdata (tbl_cfg_rdata)
   );

   emmu_table #(.IDW(IDW)) u_emmu_table
   (
      .clk           (clk),
      .tbl_cfg_en    (tbl_cfg_en),
      .tbl_cfg_wr_en (tbl_cfg_wr_en),
      .tbl_cfg_idx   (tbl_cfg_idx),
      .tbl_cfg_wdata (tbl_cfg_wdata),
      .tbl_cfg_rdata (tbl_cfg_rdata),
      .tbl_lk_en     (tbl_lk_en),
      .tbl_lk_idx    (tbl_lk_idx),
      .tbl_lk_data   (tbl_lk_data)
   );

   emmu #(.IDW(IDW)) u_emmu
   (
      .clk               (clk),
      .reset             (reset),
      .mmu_en            (mmu_en),
      .emesh_access_in   (emesh_access_in),
      .emesh_write_in    (emesh_write_in),
      .emesh_datamode_in (emesh_datamode_in),
      .emesh_ctrlmode_in (emesh_ctrlmode_in),
      .emesh_dstaddr_in  (emesh_dstaddr_in),
      .emesh_srcaddr_in  (emesh_srcaddr_in),
      .emesh_data_in     (emesh_data_in),
      .emmu_access_out   (emmu_access_out),
      .emmu_write_out    (emmu_write_out),
      .emmu_datamode_out (emmu_datamode_out),
      .emmu_ctrlmode_out (emmu_ctrlmode_out),
      .emmu_dstaddr_out  (emmu_dstaddr_out),
      .emmu_srcaddr_out  (emmu_srcaddr_out),
      .emmu_data_out     (emmu_data_out),
      .tbl_lk_en         (tbl_lk_en),
      .tbl_lk_idx        (tbl_lk_idx),
      .tbl_lk_data       (tbl_lk_data)
   );

endmodule

`default_nettype wire

// File: test/emmu_tb.sv
//==========================================================================
// Testbench for the eMesh MMU top level. Applies a table of config and
// translate steps in a loop, checks every output one cycle later against
// a software model of the translation table.
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module emmu_tb
   import emesh_pkg::*;
   import emmu_pkg::*;
();

   localparam int IDW    = 12;
   localparam int PAGE_W = EMESH_PAW - EMESH_AW + IDW;   // entry bits in the result
   localparam int OFF_W  = EMESH_AW - IDW;               // untranslated offset
   localparam int NENT   = 8;                            // entries exercised

   typedef enum logic [2:0]
   {
      OP_WR_LO, OP_WR_HI, OP_RD_LO, OP_RD_HI, OP_XLATE, OP_BYPASS, OP_IDLE
   } op_t;

   typedef struct packed
   {
      op_t            op;
      logic [IDW-1:0] idx;
      logic [31:0]    val;   // write data, offset, or full bypass address
   } step_t;

   logic clk;
   logic reset;
   logic mmu_en;
   logic mi_en;
   logic mi_we;
   logic [MI_AW-1:0] mi_addr;
   logic [MI_DW-1:0] mi_din;
   logic [MI_DW-1:0] mi_dout;
   logic emesh_access_in;
   logic emesh_write_in;
   emesh_datamode_t emesh_datamode_in;
   logic [EMESH_CTRLW-1:0] emesh_ctrlmode_in;
   logic [EMESH_AW-1:0] emesh_dstaddr_in;
   logic [EMESH_AW-1:0] emesh_srcaddr_in;
   logic [EMESH_DW-1:0] emesh_data_in;
   logic emmu_access_out;
   logic emmu_write_out;
   emesh_datamode_t emmu_datamode_out;
   logic [EMESH_CTRLW-1:0] emmu_ctrlmode_out;
   logic [EMESH_PAW-1:0] emmu_dstaddr_out;
   logic [EMESH_AW-1:0] emmu_srcaddr_out;
   logic [EMESH_DW-1:0] emmu_data_out;

   step_t steps[$];
   logic [47:0] model [0:(1<<IDW)-1];   // reference copy of the table

   // what the previous step should produce
   logic pend_access;
   logic pend_write;
   emesh_datamode_t pend_dm;
   logic [EMESH_CTRLW-1:0] pend_ctrl;
   logic [63:0] pend_dst;
   logic [31:0] pend_src;
   logic [31:0] pend_data;
   logic pend_read;
   logic [31:0] pend_rdata;
   logic [31:0] exp_dout;   // mi_dout holds last read

   int error_count;
   int cycle_count;
   int cycle_limit;

   emmu_top #(.IDW(IDW)) u_emmu_top
   (
      .clk               (clk),
      .reset             (reset),
      .mmu_en            (mmu_en),
      .mi_en             (mi_en),
      .mi_we             (mi_we),
      .mi_addr           (mi_addr),
      .mi_din            (mi_din),
      .mi_dout           (mi_dout),
      .emesh_access_in   (emesh_access_in),
      .emesh_write_in    (emesh_write_in),
      .emesh_datamode_in (emesh_datamode_in),
      .emesh_ctrlmode_in (emesh_ctrlmode_in),
      .emesh_dstaddr_in  (emesh_dstaddr_in),
      .emesh_srcaddr_in  (emesh_srcaddr_in),
      .emesh_data_in     (emesh_data_in),
      .emmu_access_out   (emmu_access_out),
      .emmu_write_out    (emmu_write_out),
      .emmu_datamode_out (emmu_datamode_out),
      .emmu_ctrlmode_out (emmu_ctrlmode_out),
      .emmu_dstaddr_out  (emmu_dstaddr_out),
      .emmu_srcaddr_out  (emmu_srcaddr_out),
      .emmu_data_out     (emmu_data_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   // guards against a stuck run
   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic check_value(string name, logic [63:0] exp, logic [63:0] got);
      assert (got === exp)
      else
      begin
         error_count++;
         $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
         $display("Simulation failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic logic [MI_AW-1:0] cfg_addr(logic [IDW-1:0] idx, logic half);
      logic [MI_AW-1:0] a;
      a = '0;
      a[IDW+2:3] = idx;   // index above the half select
      a[2] = half;
      return a;
   endfunction

   function automatic void push_step(op_t op, logic [IDW-1:0] idx, logic [31:0] val);
      step_t s;
      s.op = op;
      s.idx = idx;
      s.val = val;
      steps.push_back(s);
   endfunction

   task automatic build_steps();
      logic [IDW-1:0] ent [0:NENT-1];
      logic [31:0] r;
      for (int k = 0; k < NENT; k++)
      begin
         r = $urandom;
         ent[k] = r[IDW-1:0];
      end
      for (int k = 0; k < NENT; k++)
      begin
         push_step(OP_WR_LO, ent[k], $urandom);
         push_step(OP_WR_HI, ent[k], $urandom);   // only low 16 bits stored
      end
      for (int k = 0; k < NENT; k++)
      begin
         push_step(OP_RD_LO, ent[k], 32'h0);
         push_step(OP_RD_HI, ent[k], 32'h0);
      end
      push_step(OP_IDLE, '0, 32'h0);
      for (int k = 0; k < NENT; k++)
         push_step(OP_XLATE, ent[k], $urandom);   // back-to-back without gaps
      for (int k = 0; k < 4; k++)
         push_step(OP_BYPASS, '0, $urandom);
      // overwrite then translate again
      push_step(OP_WR_LO, ent[0], $urandom);
      push_step(OP_WR_HI, ent[0], $urandom);
      push_step(OP_XLATE, ent[0], $urandom);
      push_step(OP_WR_LO, ent[1], $urandom);
      push_step(OP_IDLE, '0, 32'h0);
      push_step(OP_XLATE, ent[1], $urandom);
      push_step(OP_BYPASS, '0, $urandom);   // mmu_en toggles per cycle
      push_step(OP_XLATE, ent[2], $urandom);
   endtask

   task automatic apply_step(step_t s);
      logic [31:0] r;
      mi_en = 1'b0;
      mi_we = 1'b0;
      emesh_access_in = 1'b0;
      pend_access = 1'b0;
      pend_read = 1'b0;
      case (s.op)
         OP_WR_LO, OP_WR_HI:
         begin
            mi_en = 1'b1;
            mi_we = 1'b1;
            mi_addr = cfg_addr(s.idx, s.op == OP_WR_HI);
            mi_din = s.val;
            if (s.op == OP_WR_HI)
               model[s.idx][47:32] = s.val[15:0];
            else
               model[s.idx][31:0] = s.val;
         end
         OP_RD_LO, OP_RD_HI:
         begin
            mi_en = 1'b1;
            mi_addr = cfg_addr(s.idx, s.op == OP_RD_HI);
            pend_read = 1'b1;
            if (s.op == OP_RD_HI)
               pend_rdata = {16'h0, model[s.idx][47:32]};   // zero-extended
            else
               pend_rdata = model[s.idx][31:0];
         end
         OP_XLATE, OP_BYPASS:
         begin
            r = $urandom;
            mmu_en = (s.op == OP_XLATE);
            emesh_access_in = 1'b1;
            emesh_write_in = r[0];
            emesh_datamode_in = emesh_datamode_t'(r[2:1]);
            emesh_ctrlmode_in = r[6:3];
            emesh_srcaddr_in = $urandom;
            emesh_data_in = $urandom;
            if (s.op == OP_XLATE)
            begin
               emesh_dstaddr_in = {s.idx, s.val[OFF_W-1:0]};
               pend_dst = {model[s.idx][PAGE_W-1:0], s.val[OFF_W-1:0]};
            end
            else
            begin
               emesh_dstaddr_in = s.val;
               pend_dst = {32'h0, s.val};   // table ignored
            end
            pend_access = 1'b1;
            pend_write = emesh_write_in;
            pend_dm = emesh_datamode_in;
            pend_ctrl = emesh_ctrlmode_in;
            pend_src = emesh_srcaddr_in;
            pend_data = emesh_data_in;
         end
         default:
         begin
         end
      endcase
   endtask

   task automatic check_outputs();
      check_value("emmu_access_out", 64'(pend_access), 64'(emmu_access_out));
      if (pend_access)
      begin
         check_value("emmu_dstaddr_out", pend_dst, emmu_dstaddr_out);
         check_value("emmu_write_out", 64'(pend_write), 64'(emmu_write_out));
         check_value("emmu_datamode_out", 64'(pend_dm), 64'(emmu_datamode_out));
         check_value("emmu_ctrlmode_out", 64'(pend_ctrl), 64'(emmu_ctrlmode_out));
         check_value("emmu_srcaddr_out", 64'(pend_src), 64'(emmu_srcaddr_out));
         check_value("emmu_data_out", 64'(pend_data), 64'(emmu_data_out));
      end
      if (pend_read)
         exp_dout = pend_rdata;
      check_value("mi_dout", 64'(exp_dout), 64'(mi_dout));
   endtask

   initial
   begin
      step_t idle_step;
      void'($urandom(32'h6d0e));
      reset = 1'b1;
      mmu_en = 1'b1;
      mi_en = 1'b0;
      mi_we = 1'b0;
      mi_addr = '0;
      mi_din = '0;
      emesh_access_in = 1'b1;   // strobe high through reset
      emesh_write_in = 1'b0;
      emesh_datamode_in = DM_BYTE;
      emesh_ctrlmode_in = '0;
      emesh_dstaddr_in = '0;
      emesh_srcaddr_in = '0;
      emesh_data_in = '0;
      pend_access = 1'b0;
      pend_read = 1'b0;
      exp_dout = '0;   // reset value
      error_count = 0;
      cycle_count = 0;
      idle_step = '{op: OP_IDLE, idx: '0, val: 32'h0};
      build_steps();
      cycle_limit = 4 * steps.size() + 100;
      repeat (8) @(posedge clk);
      #1 check_outputs();   // outputs held at reset values
      #1 reset = 1'b0;
      emesh_access_in = 1'b0;
      // check last step's result and drive the next
      for (int i = 0; i < steps.size(); i++)
      begin
         @(posedge clk);
         #1 check_outputs();
         #1 apply_step(steps[i]);
      end
      repeat (3)
      begin
         @(posedge clk);
         #1 check_outputs();
         #1 apply_step(idle_step);
      end
      if (error_count == 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
      begin
         $display("Simulation failed");
         $fatal(1, "%0d checks failed", error_count);
      end
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/emesh_pkg.sv
hw/emmu_pkg.sv
hw/emmu_table.sv
hw/emmu_cfg.sv
hw/emmu.sv
hw/emmu_top.sv
test/emmu_tb.sv

// File: Makefile
# Verilator build and run for the eMesh MMU testbench

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module emmu_tb -o Vemmu_tb

run: build
	./obj_dir/Vemmu_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "run FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module emmu_tb
	verilator --lint-only hw/emesh_pkg.sv hw/emmu_pkg.sv hw/emmu_table.sv \
		hw/emmu_cfg.sv hw/emmu.sv hw/emmu_top.sv --top-module emmu_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
